// ==== build.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f scoreboard.f --top-module tb_scoreboard -o tb_scoreboard \
    && ./obj_dir/tb_scoreboard | tee sim.log \
    && grep -qx "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== scoreboard.f ====
+incdir+testbench
source/scoreboard_pkg.sv
source/player_led_decode.sv
source/digit_encode.sv
source/digit_scan.sv
source/lcd_timing.sv
source/lcd_char_rom.sv
source/scoreboard_top.sv
testbench/tb_scoreboard.sv

// ==== source/digit_encode.sv ====
module digit_encode import scoreboard_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  count_t count,
    output seg_t   seg
);

    seg_t pattern;

    always_comb begin
        case (count)
            3'd1: pattern = 7'h30;
            3'd2: pattern = 7'h6D;
            3'd3: pattern = 7'h79;
            3'd4: pattern = 7'h33;
            3'd5: pattern = 7'h5B;
            default: pattern = '0;  // Blank digit
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            seg <= '0;
        end else begin
            seg <= pattern;
        end
    end

endmodule

// ==== source/digit_scan.sv ====
module digit_scan import scoreboard_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  seg_t      p1_seg,
    input  seg_t      p2_seg,
    output scan_pos_t seg_pos,
    output seg_t      seg_data
);

    localparam int SCAN_W = $clog2(SCAN_DIGITS);
    localparam logic [SCAN_W-1:0] LAST_POS = SCAN_W'(SCAN_DIGITS - 1);

    logic [SCAN_W-1:0] scan_cnt;
    seg_t              pos_data;

    // Player 1 on the first digit, player 2 on the last
    always_comb begin
        if (scan_cnt == '0) begin
            pos_data = p1_seg;
        end else if (scan_cnt == LAST_POS) begin
            pos_data = p2_seg;
        end else begin
            pos_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            scan_cnt <= '0;
            seg_pos  <= '0;
            seg_data <= '0;
        end else begin
            if (scan_cnt == LAST_POS) begin
                scan_cnt <= '0;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            seg_pos  <= scan_pos_t'(1) << scan_cnt;  // One-hot digit select
            seg_data <= pos_data;
        end
    end

endmodule

// ==== source/lcd_char_rom.sv ====
module lcd_char_rom import scoreboard_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lcd_step_t step,
    output lcd_bus_t  lcd
);

    localparam int COL_W = $clog2(LINE_COLS);

    function automatic logic has_winner(winner_t msg);
        return (msg == 2'd1) || (msg == 2'd2);
    endfunction

    // " P1 Win" or " P2 Win"
    function automatic logic [7:0] banner_char(winner_t msg, logic [COL_W-1:0] col);
        logic [7:0] ch;
        ch = CHAR_SPACE;
        if (has_winner(msg)) begin
            case (col)
                COL_W'(1): ch = 8'h50;  // P
                COL_W'(2): ch = (msg == 2'd1) ? 8'h31 : 8'h32;
                COL_W'(4): ch = 8'h57;  // W
                COL_W'(5): ch = 8'h69;  // i
                COL_W'(6): ch = 8'h6E;  // n
                default:   ch = CHAR_SPACE;
            endcase
        end
        return ch;
    endfunction

    // Two groups of three hearts
    function automatic logic [7:0] heart_char(winner_t msg, logic [COL_W-1:0] col);
        logic [7:0] ch;
        ch = CHAR_SPACE;
        if (has_winner(msg)) begin
            case (col)
                COL_W'(1), COL_W'(2), COL_W'(3),
                COL_W'(5), COL_W'(6), COL_W'(7): ch = CHAR_HEART;
                default: ch = CHAR_SPACE;
            endcase
        end
        return ch;
    endfunction

    logic             in_line;
    logic [COL_W-1:0] col;
    logic [7:0]       line_char;
    lcd_bus_t         bus_next;

    assign in_line = (step.index != '0) && (step.index <= lcd_index_t'(LINE_COLS));
    assign col     = COL_W'(step.index - 1'b1);

    always_comb begin
        if (!in_line) begin
            line_char = CHAR_SPACE;  // Past the last column
        end else if (step.phase == line1) begin
            line_char = banner_char(step.msg, col);
        end else begin
            line_char = heart_char(step.msg, col);
        end
    end

    always_comb begin
        bus_next.e  = 1'b1;
        bus_next.rs = 1'b0;
        bus_next.rw = 1'b0;
        case (step.phase)
            function_set:  bus_next.data = CMD_FUNCTION_SET;
            entry_mode:    bus_next.data = CMD_ENTRY_MODE;
            display_on:    bus_next.data = CMD_DISPLAY_ON;
            return_home:   bus_next.data = CMD_RETURN_HOME;
            clear_display: bus_next.data = CMD_CLEAR;
            line1, line2: begin
                if (step.index == '0) begin
                    bus_next.data = (step.phase == line1) ? CMD_LINE1_ADDR : CMD_LINE2_ADDR;
                end else begin
                    bus_next.rs   = 1'b1;  // Character write
                    bus_next.data = line_char;
                end
            end
            default: begin
                bus_next.e    = 1'b0;  // Idle during power-up
                bus_next.rs   = 1'b1;
                bus_next.rw   = 1'b1;
                bus_next.data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd.e    <= 1'b0;
            lcd.rs   <= 1'b1;
            lcd.rw   <= 1'b1;
            lcd.data <= '0;
        end else begin
            lcd <= bus_next;
        end
    end

endmodule

// ==== source/lcd_timing.sv ====
module lcd_timing import scoreboard_pkg::*; #(
    parameter int POWER_WAIT = 70,
    parameter int CMD_WAIT   = 30,
    parameter int LINE_WAIT  = 20,
    parameter int HOME_WAIT  = 400,
    parameter int CLEAR_WAIT = 200
) (
    input  logic      clk,
    input  logic      rst,
    input  winner_t   winner,
    output lcd_step_t step
);

    // Last index of each phase
    function automatic lcd_index_t phase_wait(lcd_phase_t phase);
        case (phase)
            power_wait:    return lcd_index_t'(POWER_WAIT);
            line1, line2:  return lcd_index_t'(LINE_WAIT);
            return_home:   return lcd_index_t'(HOME_WAIT);
            clear_display: return lcd_index_t'(CLEAR_WAIT);
            default:       return lcd_index_t'(CMD_WAIT);  // Init commands
        endcase
    endfunction

    function automatic lcd_phase_t next_phase(lcd_phase_t phase);
        case (phase)
            power_wait:   return function_set;
            function_set: return entry_mode;
            entry_mode:   return display_on;
            display_on:   return line1;
            line1:        return line2;
            line2:        return return_home;
            return_home:  return clear_display;
            default:      return line1;  // Frame repeats after clear
        endcase
    endfunction

    logic phase_done;
    logic frame_start;

    assign phase_done  = (step.index == phase_wait(step.phase));
    assign frame_start = (step.phase == line1) && (step.index == '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            step.phase <= power_wait;
            step.index <= '0;
            step.msg   <= '0;
        end else begin
            if (phase_done) begin
                step.phase <= next_phase(step.phase);
                step.index <= '0;
            end else begin
                step.index <= step.index + 1'b1;
            end
            if (frame_start) begin
                step.msg <= winner;  // Held for the whole frame
            end
        end
    end

endmodule

// ==== source/player_led_decode.sv ====
module player_led_decode import scoreboard_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  light_code_t p1_light,
    input  light_code_t p2_light,
    output led_pair_t   leds
);

    function automatic rgb_t decode(light_code_t code);
        rgb_t led;
        led = '0;
        case (code)
            2'd1: led.r = 1'b1;
            2'd2: led.g = 1'b1;
            2'd3: led.b = 1'b1;
            default: led = '0;  // Off
        endcase
        return led;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            leds <= '0;
        end else begin
            leds.p1 <= decode(p1_light);
            leds.p2 <= decode(p2_light);
        end
    end

endmodule

// ==== source/scoreboard_pkg.sv ====
package scoreboard_pkg;

    typedef logic [1:0] light_code_t;  // 0 off, 1 red, 2 green, 3 blue

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        rgb_t p1;
        rgb_t p2;
    } led_pair_t;

    typedef logic [2:0] count_t;
    typedef logic [6:0] seg_t;  // Segments a..g, a is MSB

    localparam int SCAN_DIGITS = 8;
    typedef logic [SCAN_DIGITS-1:0] scan_pos_t;

    typedef logic [1:0] winner_t;  // 1 player 1, 2 player 2

    typedef enum logic [2:0] {
        power_wait    = 3'd0,
        function_set  = 3'd1,
        entry_mode    = 3'd2,
        display_on    = 3'd3,
        line1         = 3'd4,
        line2         = 3'd5,
        return_home   = 3'd6,
        clear_display = 3'd7
    } lcd_phase_t;

    localparam int LCD_INDEX_W = 9;
    typedef logic [LCD_INDEX_W-1:0] lcd_index_t;

    typedef struct packed {
        lcd_phase_t phase;
        lcd_index_t index;
        winner_t    msg;
    } lcd_step_t;

    typedef struct packed {
        logic       e;
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    localparam int LINE_COLS = 16;

    localparam logic [7:0] CMD_FUNCTION_SET = 8'h3C;  // 8-bit bus, 2 lines
    localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C;
    localparam logic [7:0] CMD_LINE1_ADDR   = 8'h80;
    localparam logic [7:0] CMD_LINE2_ADDR   = 8'hC0;
    localparam logic [7:0] CMD_RETURN_HOME  = 8'h02;
    localparam logic [7:0] CMD_CLEAR        = 8'h01;
    localparam logic [7:0] CHAR_SPACE       = 8'h20;
    localparam logic [7:0] CHAR_HEART       = 8'h9D;  // Heart glyph in the LCD font

endpackage

// ==== source/scoreboard_top.sv ====
module scoreboard_top import scoreboard_pkg::*; #(
    parameter int POWER_WAIT = 70,
    parameter int CMD_WAIT   = 30,
    parameter int LINE_WAIT  = 20,
    parameter int HOME_WAIT  = 400,
    parameter int CLEAR_WAIT = 200
) (
    input  logic        clk,
    input  logic        rst,
    input  light_code_t p1_light,
    input  light_code_t p2_light,
    input  count_t      p1_count,
    input  count_t      p2_count,
    input  winner_t     winner,
    output led_pair_t   leds,
    output seg_t        seg_data,
    output scan_pos_t   seg_pos,
    output lcd_bus_t    lcd
);

    seg_t      p1_seg;
    seg_t      p2_seg;
    lcd_step_t step;

    player_led_decode u_led_decode (
        .clk      (clk),
        .rst      (rst),
        .p1_light (p1_light),
        .p2_light (p2_light),
        .leds     (leds)
    );

    digit_encode u_p1_digit (
        .clk   (clk),
        .rst   (rst),
        .count (p1_count),
        .seg   (p1_seg)
    );

    digit_encode u_p2_digit (
        .clk   (clk),
        .rst   (rst),
        .count (p2_count),
        .seg   (p2_seg)
    );

    digit_scan u_digit_scan (
        .clk      (clk),
        .rst      (rst),
        .p1_seg   (p1_seg),
        .p2_seg   (p2_seg),
        .seg_pos  (seg_pos),
        .seg_data (seg_data)
    );

    lcd_timing #(
        .POWER_WAIT (POWER_WAIT),
        .CMD_WAIT   (CMD_WAIT),
        .LINE_WAIT  (LINE_WAIT),
        .HOME_WAIT  (HOME_WAIT),
        .CLEAR_WAIT (CLEAR_WAIT)
    ) u_lcd_timing (
        .clk    (clk),
        .rst    (rst),
        .winner (winner),
        .step   (step)
    );

    lcd_char_rom u_lcd_char_rom (
        .clk  (clk),
        .rst  (rst),
        .step (step),
        .lcd  (lcd)
    );

endmodule

// ==== testbench/scoreboard_model.svh ====
`ifndef SCOREBOARD_MODEL_SVH
`define SCOREBOARD_MODEL_SVH

function automatic rgb_t rgb_for_code(input light_code_t code);
    rgb_t led;
    led.r = (code == 2'd1);
    led.g = (code == 2'd2);
    led.b = (code == 2'd3);
    return led;
endfunction

function automatic seg_t pattern_for_count(input count_t count);
    case (count)
        3'd1: return 7'h30;
        3'd2: return 7'h6D;
        3'd3: return 7'h79;
        3'd4: return 7'h33;
        3'd5: return 7'h5B;
        default: return 7'h00;
    endcase
endfunction

// Last index of a phase
function automatic int phase_length(input lcd_phase_t phase);
    if (phase == power_wait) return POWER_WAIT;
    if (phase == line1 || phase == line2) return LINE_WAIT;
    if (phase == return_home) return HOME_WAIT;
    if (phase == clear_display) return CLEAR_WAIT;
    return CMD_WAIT;
endfunction

function automatic lcd_phase_t phase_after(input lcd_phase_t phase);
    if (phase == clear_display) return line1;  // Back to the first line
    return lcd_phase_t'(phase + 3'd1);
endfunction

function automatic logic [7:0] line_char(input lcd_phase_t phase, input int col,
                                         input winner_t msg);
    string banner;
    banner = (msg == 2'd1) ? " P1 Win" : " P2 Win";
    if (msg != 2'd1 && msg != 2'd2) return 8'h20;
    if (phase == line1) begin
        if (col < banner.len()) return banner[col];
        return 8'h20;
    end
    if ((col >= 1 && col <= 3) || (col >= 5 && col <= 7)) return 8'h9D;  // Hearts
    return 8'h20;
endfunction

function automatic lcd_bus_t bus_for_step(input lcd_phase_t phase, input int index,
                                          input winner_t msg);
    lcd_bus_t bus;
    bus.e  = 1'b1;
    bus.rs = 1'b0;
    bus.rw = 1'b0;
    case (phase)
        function_set:  bus.data = 8'h3C;
        entry_mode:    bus.data = 8'h06;
        display_on:    bus.data = 8'h0C;
        return_home:   bus.data = 8'h02;
        clear_display: bus.data = 8'h01;
        line1, line2: begin
            if (index == 0) begin
                bus.data = (phase == line1) ? 8'h80 : 8'hC0;
            end else begin
                bus.rs   = 1'b1;
                bus.data = (index <= LINE_COLS) ? line_char(phase, index - 1, msg) : 8'h20;
            end
        end
        default: begin
            bus = 11'h300;  // Idle bus while powering up
        end
    endcase
    return bus;
endfunction

`endif

// ==== testbench/tb_scoreboard.sv ====
module tb_scoreboard import scoreboard_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int POWER_WAIT   = 5;
    localparam int CMD_WAIT     = 3;
    localparam int LINE_WAIT    = 20;
    localparam int HOME_WAIT    = 6;
    localparam int CLEAR_WAIT   = 4;
    localparam int LED_PAIRS    = 200;
    localparam int DIGIT_HOLDS  = 12;
    localparam int HOLD_CYCLES  = 16;
    localparam int INIT_CYCLES  = POWER_WAIT + 1 + 3 * (CMD_WAIT + 1);
    localparam int FRAME_CYCLES = 2 * (LINE_WAIT + 1) + HOME_WAIT + 1 + CLEAR_WAIT + 1;
    localparam int TEST_CYCLES  = RESET_CYCLES + INIT_CYCLES + LED_PAIRS
                                + DIGIT_HOLDS * HOLD_CYCLES + 5 * FRAME_CYCLES;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD + 200;

    logic        clk;
    logic        rst;
    light_code_t p1_light;
    light_code_t p2_light;
    count_t      p1_count;
    count_t      p2_count;
    winner_t     winner;
    led_pair_t   leds;
    seg_t        seg_data;
    scan_pos_t   seg_pos;
    lcd_bus_t    lcd;

    logic        checking;
    logic [31:0] rand_state;

    led_pair_t   exp_leds;
    scan_pos_t   exp_seg_pos;
    seg_t        exp_seg_data;
    lcd_bus_t    exp_lcd;
    string       lcd_test;
    logic [2:0]  model_scan;
    seg_t        model_p1_seg;
    seg_t        model_p2_seg;
    lcd_phase_t  model_phase;
    int          model_index;
    winner_t     model_msg;

    `include "scoreboard_model.svh"

    scoreboard_top #(
        .POWER_WAIT (POWER_WAIT),
        .CMD_WAIT   (CMD_WAIT),
        .LINE_WAIT  (LINE_WAIT),
        .HOME_WAIT  (HOME_WAIT),
        .CLEAR_WAIT (CLEAR_WAIT)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .p1_light (p1_light),
        .p2_light (p2_light),
        .p1_count (p1_count),
        .p2_count (p2_count),
        .winner   (winner),
        .leds     (leds),
        .seg_data (seg_data),
        .seg_pos  (seg_pos),
        .lcd      (lcd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[30:15];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    // Expected registers stepped on the same edges as the DUT
    always @(posedge clk) begin
        if (!rst) begin
            exp_leds     = '0;
            exp_seg_pos  = '0;
            exp_seg_data = '0;
            exp_lcd      = bus_for_step(power_wait, 0, 2'd0);
            lcd_test     = "lcd_init";
            model_scan   = '0;
            model_p1_seg = '0;
            model_p2_seg = '0;
            model_phase  = power_wait;
            model_index  = 0;
            model_msg    = '0;
        end else begin
            exp_leds.p1  = rgb_for_code(p1_light);
            exp_leds.p2  = rgb_for_code(p2_light);
            exp_seg_pos  = '0;
            exp_seg_pos[model_scan] = 1'b1;
            exp_seg_data = (model_scan == 3'd0) ? model_p1_seg :
                           (model_scan == 3'(SCAN_DIGITS - 1)) ? model_p2_seg : '0;
            if (model_scan == 3'(SCAN_DIGITS - 1)) begin
                model_scan = '0;
            end else begin
                model_scan = model_scan + 3'd1;
            end
            model_p1_seg = pattern_for_count(p1_count);
            model_p2_seg = pattern_for_count(p2_count);
            exp_lcd = bus_for_step(model_phase, model_index, model_msg);  // Bus lags one step
            if (model_phase == line1) begin
                lcd_test = "lcd_frame";
            end
            if (model_phase == line1 && model_index == 0) begin
                model_msg = winner;
            end
            if (model_index == phase_length(model_phase)) begin
                model_phase = phase_after(model_phase);
                model_index = 0;
            end else begin
                model_index++;
            end
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            check_value("leds", 32'(exp_leds), 32'(leds));
            check_value("seg_pos", 32'(exp_seg_pos), 32'(seg_pos));
            check_value("seg_data", 32'(exp_seg_data), 32'(seg_data));
            check_value(lcd_test, 32'(exp_lcd), 32'(lcd));
        end
    end

    task automatic wait_for_phase(input lcd_phase_t phase);
        @(negedge clk);
        while (model_phase != phase) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_state_test();
        @(posedge clk);  // First cycle out of reset
        @(negedge clk);
        check_value("reset_leds", 32'd0, 32'(leds));
        check_value("reset_seg_data", 32'd0, 32'(seg_data));
        check_value("reset_seg_pos", 32'd1, 32'(seg_pos));
        while (model_phase == power_wait) begin
            check_value("reset_lcd_idle", 32'h300, 32'(lcd));
            @(negedge clk);
        end
    endtask

    task automatic led_decode_test();
        logic [15:0] r;
        repeat (LED_PAIRS) begin
            r = next_random();
            @(posedge clk);
            p1_light <= r[1:0];
            p2_light <= r[5:4];
        end
    endtask

    task automatic digit_scan_test();
        logic [15:0] r;
        repeat (DIGIT_HOLDS) begin
            r = next_random();
            @(posedge clk);
            p1_count <= r[2:0];
            p2_count <= r[10:8];
            repeat (HOLD_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic lcd_message_test();
        winner_t     w;
        logic [15:0] r;
        int          f;
        for (f = 0; f < 3; f++) begin
            w = (f == 0) ? 2'd1 : (f == 1) ? 2'd2 : 2'd0;
            r = next_random();
            wait_for_phase(return_home);  // Before the next frame latches
            @(posedge clk);
            winner <= w;
            wait_for_phase(line2);
            @(posedge clk);
            winner <= w ^ (2'd1 + 2'(r[0]));  // Must not reach this frame
        end
        wait_for_phase(line1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Finished with errors");
        $fatal(1, "Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
    end

    initial begin
        rst        = 1'b0;
        p1_light   = '0;
        p2_light   = '0;
        p1_count   = '0;
        p2_count   = '0;
        winner     = '0;
        checking   = 1'b0;
        rand_state = 32'hc9c3;
        @(posedge clk);
        checking = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst <= 1'b1;
        reset_state_test();
        led_decode_test();
        digit_scan_test();
        lcd_message_test();
        @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule
